// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid,
    input  logic              abort,
    input  cpu_pkg::alu_op_e  op,
    input  logic [31:0]       src1,
    input  logic [31:0]       src2,
    output logic [31:0]       result,
    output logic              overflow,
    output logic              ready
);
    import cpu_pkg::*;

    logic        is_div;
    logic [31:0] sum;
    logic [31:0] diff;
    logic [4:0]  sa;
    logic        div_done;
    logic [31:0] div_q;

    assign is_div = (op == alu_div) || (op == alu_divu);
    assign sum    = src1 + src2;
    assign diff   = src1 - src2;
    assign sa     = src1[4:0];

    divider divider_i (
        .clk       (clk),
        .reset     (reset),
        .start     (valid && is_div),   // held for as long as the instruction sits here
        .is_signed (op == alu_div),
        .abort     (abort),
        .dividend  (src1),
        .divisor   (src2),
        .done      (div_done),
        .quotient  (div_q)
    );

    assign ready = is_div ? div_done : 1'b1;

    always_comb begin
        overflow = 1'b0;
        case (op)
            alu_add: overflow = (src1[31] == src2[31]) && (sum[31] != src1[31]);
            alu_sub: overflow = (src1[31] != src2[31]) && (diff[31] != src1[31]);
            default: overflow = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            alu_add,
            alu_addu: result = sum;
            alu_sub,
            alu_subu: result = diff;
            alu_and:  result = src1 & src2;
            alu_or:   result = src1 | src2;
            alu_xor:  result = src1 ^ src2;
            alu_nor:  result = ~(src1 | src2);
            alu_slt:  result = {31'b0, $signed(src1) < $signed(src2)};
            alu_sltu: result = {31'b0, src1 < src2};
            alu_sll:  result = src2 << sa;
            alu_srl:  result = src2 >> sa;
            alu_sra:  result = $unsigned($signed(src2) >>> sa);
            alu_lui:  result = {src2[15:0], 16'b0};
            alu_div,
            alu_divu: result = div_q;
            default:  result = '0;
        endcase
    end

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

    localparam int div_steps = 32; // one quotient bit per iteration

    typedef enum logic [4:0] {
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui,
        alu_div,
        alu_divu
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb,
        mem_lbu,
        mem_lh,
        mem_lhu,
        mem_lw,
        mem_sb,
        mem_sh,
        mem_sw
    } mem_op_e;

    typedef enum logic [4:0] {
        exc_none = 5'd0,
        exc_adel = 5'd4,  // load address error
        exc_ades = 5'd5,  // store address error
        exc_ov   = 5'd12
    } exc_code_e;

    typedef enum logic [1:0] {
        src2_rt,
        src2_zimm,        // zero-extended immediate
        src2_simm         // sign-extended immediate
    } src2_sel_e;

    // decoded instruction entering execute
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs_value;
        logic [31:0] rt_value;
        logic [15:0] imm;
        logic [4:0]  dest;
        logic        gr_we;
        alu_op_e     alu_op;
        mem_op_e     mem_op;
        logic        src1_is_sa;
        src2_sel_e   src2_sel;
    } ds_to_es_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] alu_result;  // also the memory byte address
        logic [31:0] rt_value;
        logic [4:0]  dest;
        logic        gr_we;
        mem_op_e     mem_op;
        exc_code_e   exc;
    } es_to_ms_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [4:0]  dest;
        logic        gr_we;       // already cleared on exception
        exc_code_e   exc;
    } ms_to_ws_t;

endpackage

// File: data_ram.sv
`timescale 1ns/1ps

module data_ram #(
    parameter int ram_addr_bits = 10
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic [3:0]               wen,
    input  logic [ram_addr_bits-1:0] addr,
    input  logic [31:0]              wdata,
    output logic [31:0]              rdata
);

    localparam int depth = 2 ** ram_addr_bits;

    logic [31:0] mem [depth];

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = 32'h0;
        end
    end

    // read-first, rdata holds when en is low
    always @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
            for (int b = 0; b < 4; b++) begin
                if (wen[b]) mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

endmodule

// File: divider.sv
`timescale 1ns/1ps

module divider (
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic        is_signed,
    input  logic        abort,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic        done,
    output logic [31:0] quotient
);
    import cpu_pkg::*;

    localparam int cnt_bits = $clog2(div_steps);

    logic                busy;
    logic [cnt_bits-1:0] cnt;
    logic [31:0]         rem;
    logic [31:0]         quo;          // dividend shifts out, quotient shifts in
    logic [31:0]         div_mag;
    logic                neg_q;
    logic                a_neg;
    logic                b_neg;
    logic [33:0]         trial;
    logic [31:0]         rem_next;
    logic [31:0]         quo_next;
    logic                last_step;

    assign a_neg = is_signed & dividend[31];
    assign b_neg = is_signed & divisor[31];
    assign last_step = busy && (int'(cnt) == div_steps - 1);

    // restoring step, borrow in bit 33
    always_comb begin
        trial = {1'b0, rem, quo[31]} - {2'b00, div_mag};
        if (!trial[33]) begin
            rem_next = trial[31:0];
            quo_next = {quo[30:0], 1'b1};
        end else begin
            rem_next = {rem[30:0], quo[31]};
            quo_next = {quo[30:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (abort) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (last_step) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (done) begin
            if (!start) done <= 1'b0;     // hold result until start drops
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy && !done) begin
            rem     <= '0;
            quo     <= a_neg ? -dividend : dividend;
            div_mag <= b_neg ? -divisor : divisor;
            neg_q   <= a_neg ^ b_neg;
        end else if (busy) begin
            rem <= rem_next;
            quo <= quo_next;
            if (last_step) quotient <= neg_q ? -quo_next : quo_next;
        end
    end

endmodule

// File: exe_mem_props.sv
`timescale 1ns/1ps

module exe_mem_props (
    input logic               clk,
    input logic               reset,
    input logic               flush,
    input logic               ws_valid,
    input logic               ws_allowin,
    input cpu_pkg::ms_to_ws_t ws_bus,
    input logic               ms_ex,
    input logic [3:0]         ram_wen
);
    import cpu_pkg::*;

    // a stalled output record stays put unless flushed
    assert property (@(posedge clk) disable iff (reset)
        (ws_valid && !ws_allowin && !flush) |=> (ws_valid && $stable(ws_bus)))
        else $error("output record changed while ws_allowin was low");

    assert property (@(posedge clk) disable iff (reset)
        (ms_ex || flush) |-> (ram_wen == 4'b0000))
        else $error("RAM write enabled behind an exception or during a flush");

    assert property (@(posedge clk)
        reset |=> !ws_valid)
        else $error("ws_valid high after reset");

endmodule

bind exe_mem_top exe_mem_props props_i (
    .clk        (clk),
    .reset      (reset),
    .flush      (flush),
    .ws_valid   (ws_valid),
    .ws_allowin (ws_allowin),
    .ws_bus     (ws_bus),
    .ms_ex      (ms_ex),
    .ram_wen    (ram_wen)
);

// File: exe_mem_top.sv
`timescale 1ns/1ps

module exe_mem_top #(
    parameter int ram_addr_bits = 10
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               ds_valid,
    input  cpu_pkg::ds_to_es_t ds_bus,
    input  logic               ws_allowin,
    output logic               es_allowin,
    output logic               ws_valid,
    output cpu_pkg::ms_to_ws_t ws_bus
);
    import cpu_pkg::*;

    logic                     es_to_ms_valid;
    es_to_ms_t                es_to_ms_bus;
    logic                     ms_allowin;
    logic                     ms_ex;
    logic                     ram_en;
    logic [3:0]               ram_wen;
    logic [ram_addr_bits-1:0] ram_addr;
    logic [31:0]              ram_wdata;
    logic [31:0]              ram_rdata;

    exe_stage #(
        .ram_addr_bits (ram_addr_bits)
    ) exe_stage_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .ds_valid       (ds_valid),
        .ds_bus         (ds_bus),
        .ms_allowin     (ms_allowin),
        .ms_ex          (ms_ex),
        .es_allowin     (es_allowin),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ram_en         (ram_en),
        .ram_wen        (ram_wen),
        .ram_addr       (ram_addr),
        .ram_wdata      (ram_wdata)
    );

    data_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) data_ram_i (
        .clk   (clk),
        .en    (ram_en),
        .wen   (ram_wen),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    mem_stage mem_stage_i (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ram_rdata      (ram_rdata),
        .ws_allowin     (ws_allowin),
        .ms_allowin     (ms_allowin),
        .ms_ex          (ms_ex),
        .ws_valid       (ws_valid),
        .ws_bus         (ws_bus)
    );

endmodule

// File: exe_stage.sv
`timescale 1ns/1ps

module exe_stage #(
    parameter int ram_addr_bits = 10
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     flush,
    input  logic                     ds_valid,
    input  cpu_pkg::ds_to_es_t       ds_bus,
    input  logic                     ms_allowin,
    input  logic                     ms_ex,
    output logic                     es_allowin,
    output logic                     es_to_ms_valid,
    output cpu_pkg::es_to_ms_t       es_to_ms_bus,
    output logic                     ram_en,
    output logic [3:0]               ram_wen,
    output logic [ram_addr_bits-1:0] ram_addr,
    output logic [31:0]              ram_wdata
);
    import cpu_pkg::*;

    logic        es_valid;
    ds_to_es_t   es_bus_r;
    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_result;
    logic        alu_ov;
    logic        es_ready_go;
    logic        es_handoff;
    logic [1:0]  addr_lo;
    logic [3:0]  store_wen;
    logic [31:0] store_data;
    logic        ades;
    logic        adel;
    exc_code_e   es_exc;

    assign es_allowin     = !es_valid || (es_ready_go && ms_allowin);
    assign es_to_ms_valid = es_valid && es_ready_go;
    assign es_handoff     = es_to_ms_valid && ms_allowin;

    // flush also drops anything accepted on the same edge
    always_ff @(posedge clk) begin
        if (reset || flush) es_valid <= 1'b0;
        else if (es_allowin) es_valid <= ds_valid;
    end

    always_ff @(posedge clk) begin
        if (ds_valid && es_allowin) es_bus_r <= ds_bus;
    end

    assign src1 = es_bus_r.src1_is_sa ? {27'b0, es_bus_r.imm[10:6]} : es_bus_r.rs_value;

    always_comb begin
        case (es_bus_r.src2_sel)
            src2_zimm: src2 = {16'b0, es_bus_r.imm};
            src2_simm: src2 = {{16{es_bus_r.imm[15]}}, es_bus_r.imm};
            default:   src2 = es_bus_r.rt_value;
        endcase
    end

    alu alu_i (
        .clk      (clk),
        .reset    (reset),
        .valid    (es_valid),
        .abort    (flush || es_handoff),  // handoff clears a finished divide
        .op       (es_bus_r.alu_op),
        .src1     (src1),
        .src2     (src2),
        .result   (alu_result),
        .overflow (alu_ov),
        .ready    (es_ready_go)
    );

    assign addr_lo = alu_result[1:0];

    // lane replication and byte enables
    always_comb begin
        case (es_bus_r.mem_op)
            mem_sb: begin
                store_data = {4{es_bus_r.rt_value[7:0]}};
                store_wen  = 4'b0001 << addr_lo;
            end
            mem_sh: begin
                store_data = {2{es_bus_r.rt_value[15:0]}};
                store_wen  = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            mem_sw: begin
                store_data = es_bus_r.rt_value;
                store_wen  = 4'b1111;
            end
            default: begin
                store_data = es_bus_r.rt_value;
                store_wen  = 4'b0000;
            end
        endcase
    end

    assign ades = (es_bus_r.mem_op == mem_sh && addr_lo[0])
               || (es_bus_r.mem_op == mem_sw && addr_lo != 2'b00);
    assign adel = ((es_bus_r.mem_op == mem_lh || es_bus_r.mem_op == mem_lhu) && addr_lo[0])
               || (es_bus_r.mem_op == mem_lw && addr_lo != 2'b00);

    assign es_exc = alu_ov ? exc_ov :
                    ades   ? exc_ades :
                    adel   ? exc_adel : exc_none;

    // request goes out on the handoff edge only
    assign ram_en    = es_handoff && (es_bus_r.mem_op != mem_none);
    assign ram_wen   = (es_handoff && es_exc == exc_none && !ms_ex && !flush) ? store_wen : 4'b0;
    assign ram_addr  = alu_result[ram_addr_bits+1:2];
    assign ram_wdata = store_data;

    assign es_to_ms_bus = '{
        pc:         es_bus_r.pc,
        alu_result: alu_result,
        rt_value:   es_bus_r.rt_value,
        dest:       es_bus_r.dest,
        gr_we:      es_bus_r.gr_we,
        mem_op:     es_bus_r.mem_op,
        exc:        es_exc
    };

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               flush,
    input  logic               es_to_ms_valid,
    input  cpu_pkg::es_to_ms_t es_to_ms_bus,
    input  logic [31:0]        ram_rdata,
    input  logic               ws_allowin,
    output logic               ms_allowin,
    output logic               ms_ex,
    output logic               ws_valid,
    output cpu_pkg::ms_to_ws_t ws_bus
);
    import cpu_pkg::*;

    logic        ms_valid;
    es_to_ms_t   ms_bus_r;
    logic [1:0]  addr_lo;
    logic [7:0]  load_byte;
    logic [15:0] load_half;
    logic [31:0] result;

    assign ms_allowin = !ms_valid || ws_allowin;   // always ready
    assign ws_valid   = ms_valid;
    assign ms_ex      = ms_valid && (ms_bus_r.exc != exc_none);

    always_ff @(posedge clk) begin
        if (reset || flush) ms_valid <= 1'b0;
        else if (ms_allowin) ms_valid <= es_to_ms_valid;
    end

    always_ff @(posedge clk) begin
        if (es_to_ms_valid && ms_allowin) ms_bus_r <= es_to_ms_bus;
    end

    assign addr_lo   = ms_bus_r.alu_result[1:0];
    assign load_byte = ram_rdata[{addr_lo, 3'b000} +: 8];
    assign load_half = addr_lo[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (ms_bus_r.mem_op)
            mem_lb:  result = {{24{load_byte[7]}}, load_byte};
            mem_lbu: result = {24'b0, load_byte};
            mem_lh:  result = {{16{load_half[15]}}, load_half};
            mem_lhu: result = {16'b0, load_half};
            mem_lw:  result = ram_rdata;
            default: result = ms_bus_r.alu_result;  // stores and plain ALU ops
        endcase
    end

    // an excepting record never writes the register file
    assign ws_bus = '{
        pc:     ms_bus_r.pc,
        result: result,
        dest:   ms_bus_r.dest,
        gr_we:  ms_bus_r.gr_we && (ms_bus_r.exc == exc_none),
        exc:    ms_bus_r.exc
    };

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the exe/mem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_exe_mem -f sim.f \
    --Mdir obj_dir -o sim_exe_mem

./obj_dir/sim_exe_mem > sim.log 2>&1 || true
cat sim.log

if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then
    exit 1
fi

// File: sim.f
cpu_pkg.sv
divider.sv
alu.sv
exe_stage.sv
data_ram.sv
mem_stage.sv
exe_mem_top.sv
exe_mem_props.sv
tb_exe_mem.sv

// File: tb_exe_mem.sv
`timescale 1ns/1ps

module tb_exe_mem;
    import cpu_pkg::*;

    localparam int ram_addr_bits = 10;
    localparam int max_instr     = 250;
    localparam int cycle_limit   = max_instr * (div_steps + 10);

    logic        clk;
    logic        reset;
    logic        flush;
    logic        ds_valid;
    ds_to_es_t   ds_bus;
    logic        ws_allowin;
    logic        es_allowin;
    logic        ws_valid;
    ms_to_ws_t   ws_bus;

    logic [31:0] model_mem [2 ** ram_addr_bits];
    ms_to_ws_t   exp_q [$];
    logic [31:0] rand_state = 32'd16728;
    logic [31:0] next_pc = 32'hbfc0_0000;
    string       cur_test;
    bit          stall_mode = 0;
    bit          prev_exc = 0;   // record just ahead in the pipeline excepted
    int          cycles = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    exe_mem_top #(.ram_addr_bits(ram_addr_bits)) exe_mem_top_i (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .ds_valid   (ds_valid),
        .ds_bus     (ds_bus),
        .ws_allowin (ws_allowin),
        .es_allowin (es_allowin),
        .ws_valid   (ws_valid),
        .ws_bus     (ws_bus)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // truncating division on magnitudes, zero divisor gives all ones
    function automatic logic [31:0] quotient(logic [31:0] a, logic [31:0] b, bit sgn);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        q  = (mb == 0) ? 32'hffff_ffff : ma / mb;
        return (sgn && (a[31] ^ b[31])) ? -q : q;
    endfunction

    // expected writeback record, updates the model memory
    function automatic ms_to_ws_t model_step(ds_to_es_t d);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] word;
        longint      s;
        logic        ov;
        logic [1:0]  lo;
        int          idx;
        exc_code_e   exc;
        ms_to_ws_t   o;
        a = d.src1_is_sa ? {27'b0, d.imm[10:6]} : d.rs_value;
        case (d.src2_sel)
            src2_zimm: b = {16'b0, d.imm};
            src2_simm: b = {{16{d.imm[15]}}, d.imm};
            default:   b = d.rt_value;
        endcase
        s = 0;
        case (d.alu_op)
            alu_add, alu_addu: r = a + b;
            alu_sub, alu_subu: r = a - b;
            alu_and:  r = a & b;
            alu_or:   r = a | b;
            alu_xor:  r = a ^ b;
            alu_nor:  r = ~(a | b);
            alu_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            alu_sll:  r = b << a[4:0];
            alu_srl:  r = b >> a[4:0];
            alu_sra:  r = $unsigned($signed(b) >>> a[4:0]);
            alu_lui:  r = {b[15:0], 16'h0};
            alu_div:  r = quotient(a, b, 1'b1);
            default:  r = quotient(a, b, 1'b0);
        endcase
        if (d.alu_op == alu_add) s = longint'($signed(a)) + longint'($signed(b));
        if (d.alu_op == alu_sub) s = longint'($signed(a)) - longint'($signed(b));
        ov = (d.alu_op inside {alu_add, alu_sub}) && (s != longint'($signed(r)));
        lo  = r[1:0];
        idx = int'(r[ram_addr_bits+1:2]);
        if (ov) exc = exc_ov;
        else if ((d.mem_op == mem_sh && lo[0]) || (d.mem_op == mem_sw && lo != 0)) exc = exc_ades;
        else if ((d.mem_op inside {mem_lh, mem_lhu} && lo[0]) || (d.mem_op == mem_lw && lo != 0))
            exc = exc_adel;
        else exc = exc_none;
        word = model_mem[idx];
        case (d.mem_op)
            mem_lb:  r = {{24{word[8*lo+7]}}, word[8*lo +: 8]};
            mem_lbu: r = {24'h0, word[8*lo +: 8]};
            mem_lh:  r = {{16{word[16*lo[1]+15]}}, word[16*lo[1] +: 16]};
            mem_lhu: r = {16'h0, word[16*lo[1] +: 16]};
            mem_lw:  r = word;
            default: ;
        endcase
        if (exc == exc_none && !prev_exc) begin  // no write behind an excepting record
            case (d.mem_op)
                mem_sb:  word[8*lo +: 8] = d.rt_value[7:0];
                mem_sh:  word[16*lo[1] +: 16] = d.rt_value[15:0];
                mem_sw:  word = d.rt_value;
                default: ;
            endcase
            model_mem[idx] = word;
        end
        prev_exc = (exc != exc_none);
        o.pc     = d.pc;
        o.result = r;
        o.dest   = d.dest;
        o.gr_we  = d.gr_we && (exc == exc_none);
        o.exc    = exc;
        return o;
    endfunction

    function automatic ds_to_es_t build(alu_op_e op, mem_op_e mop, logic [31:0] rs,
                                        logic [31:0] rt, logic [15:0] imm, src2_sel_e sel);
        ds_to_es_t d;
        d          = '0;
        d.pc       = next_pc;
        d.rs_value = rs;
        d.rt_value = rt;
        d.imm      = imm;
        d.dest     = 5'(next_rand());
        d.gr_we    = !(mop inside {mem_sb, mem_sh, mem_sw});
        d.alu_op   = op;
        d.mem_op   = mop;
        d.src2_sel = sel;
        next_pc    = next_pc + 32'd4;
        return d;
    endfunction

    function automatic ds_to_es_t mem_instr(mem_op_e mop, logic [31:0] addr, logic [31:0] data);
        return build(alu_addu, mop, addr, data, 16'h0, src2_simm);
    endfunction

    // caller sits at a falling edge, returns at the falling edge after acceptance
    task automatic present(input ds_to_es_t d);
        ds_bus   = d;
        ds_valid = 1'b1;
        #1;
        while (!es_allowin) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        ds_valid = 1'b0;
    endtask

    task automatic issue(input ds_to_es_t d);
        exp_q.push_back(model_step(d));
        present(d);
    endtask

    task automatic finish_test();
        while (exp_q.size() != 0) @(negedge clk);
        repeat (3) @(negedge clk);
        prev_exc = 0;
        $display("test %s done, %0d errors", cur_test, test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        test_errors = 0;
    endtask

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    // output side: random stalls and the compare against the model
    initial begin
        ms_to_ws_t exp;
        ws_allowin = 1'b1;
        forever begin
            @(negedge clk);
            ws_allowin = stall_mode ? (next_rand() % 3 != 0) : 1'b1;
            #1;
            if (!reset && ws_valid && ws_allowin) begin
                if (exp_q.size() == 0) begin
                    $display("%s: a record came out that no instruction should produce", cur_test);
                    note_error();
                end else begin
                    exp = exp_q.pop_front();
                    assert (ws_bus === exp) else begin
                        $display("ERROR %s: expected %h, actual %h", cur_test, exp, ws_bus);
                        note_error();
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        ds_to_es_t d;
        int        cnt;
        int        k;
        logic [31:0] off;
        reset    = 1'b1;
        flush    = 1'b0;
        ds_valid = 1'b0;
        ds_bus   = '0;
        for (int i = 0; i < 2 ** ram_addr_bits; i++) model_mem[i] = 32'h0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        cur_test = "alu";
        for (int i = 0; i < 40; i++) begin
            d = build(alu_op_e'(5'(next_rand() % 14)), mem_none, next_rand(), next_rand(),
                      16'(next_rand()), src2_sel_e'(2'(next_rand() % 3)));
            d.src1_is_sa = (next_rand() % 2) == 1;
            issue(d);
        end
        finish_test();
        cur_test = "latency";
        issue(build(alu_addu, mem_none, 32'd5, 32'd6, 16'h0, src2_rt));
        cnt = 1;
        #1;
        while (!ws_valid && cnt < 10) begin
            @(negedge clk);
            #1;
            cnt++;
        end
        assert (cnt == 2) else begin
            $display("ERROR latency: expected %0d, actual %0d", 2, cnt);
            note_error();
        end
        finish_test();

        cur_test = "div";
        issue(build(alu_div, mem_none, 32'd100, 32'd7, 16'h0, src2_rt));
        issue(build(alu_addu, mem_none, 32'd1, 32'd2, 16'h0, src2_rt));
        issue(build(alu_div, mem_none, -32'd100, 32'd7, 16'h0, src2_rt));
        issue(build(alu_div, mem_none, 32'd100, -32'd7, 16'h0, src2_rt));
        issue(build(alu_div, mem_none, -32'd100, -32'd7, 16'h0, src2_rt));
        issue(build(alu_divu, mem_none, -32'd100, 32'd7, 16'h0, src2_rt));
        issue(build(alu_divu, mem_none, 32'd1234, 32'd0, 16'h0, src2_rt));
        issue(build(alu_div, mem_none, 32'd1234, 32'd0, 16'h0, src2_rt));
        issue(build(alu_div, mem_none, -32'd5, 32'd0, 16'h0, src2_rt));
        for (int i = 0; i < 6; i++) begin
            issue(build((i % 2 == 0) ? alu_div : alu_divu, mem_none, next_rand(),
                        next_rand() >> (i * 5), 16'h0, src2_rt));
            issue(build(alu_xor, mem_none, next_rand(), next_rand(), 16'h0, src2_rt));
        end
        finish_test();

        cur_test = "store_load";
        issue(mem_instr(mem_sw, 32'h100, 32'h1122_3344));
        issue(mem_instr(mem_sw, 32'h104, 32'h5566_7788));
        issue(mem_instr(mem_sb, 32'h101, 32'h0000_00ab));
        issue(mem_instr(mem_sh, 32'h106, 32'h0000_8765));
        issue(mem_instr(mem_sb, 32'h104, 32'h0000_00f0));
        for (int a = 32'h100; a < 32'h108; a++) begin
            issue(mem_instr(mem_lb, a, 32'h0));
            issue(mem_instr(mem_lbu, a, 32'h0));
        end
        for (int a = 32'h100; a < 32'h108; a += 2) begin
            issue(mem_instr(mem_lh, a, 32'h0));
            issue(mem_instr(mem_lhu, a, 32'h0));
        end
        issue(mem_instr(mem_lw, 32'h100, 32'h0));
        issue(mem_instr(mem_lw, 32'h104, 32'h0));
        finish_test();

        // each excepting instruction drains before the next one
        cur_test = "exceptions";
        issue(mem_instr(mem_sw, 32'h200, 32'hcafe_f00d));
        issue(build(alu_add, mem_none, 32'h7fff_ffff, 32'd1, 16'h0, src2_rt));
        issue(mem_instr(mem_sb, 32'h200, 32'h0000_0033));  // hands off while ms_ex is high
        finish_test();
        issue(mem_instr(mem_sh, 32'h201, 32'h0000_1111));
        finish_test();
        issue(mem_instr(mem_sw, 32'h202, 32'h2222_2222));
        finish_test();
        issue(mem_instr(mem_lw, 32'h200, 32'h0));
        issue(mem_instr(mem_lh, 32'h203, 32'h0));
        finish_test();
        issue(mem_instr(mem_lhu, 32'h201, 32'h0));
        finish_test();
        issue(mem_instr(mem_lw, 32'h201, 32'h0));
        finish_test();

        cur_test = "stalls";
        stall_mode = 1;
        for (int i = 0; i < 60; i++) begin
            k   = int'(next_rand() % 8);
            off = 32'h300 + (next_rand() % 64);
            if (k < 4) begin
                issue(build((k == 0) ? alu_addu : alu_op_e'(5'(3 + next_rand() % 11)), mem_none,
                            next_rand(), next_rand(), 16'(next_rand()), src2_rt));
            end else if (k == 4) begin
                issue(mem_instr(mem_sb, off, next_rand()));
                issue(mem_instr(mem_sh, off & ~32'd1, next_rand()));
                issue(mem_instr(mem_sw, off & ~32'd3, next_rand()));
            end else if (k < 7) begin
                issue(mem_instr(mem_op_e'(4'(1 + next_rand() % 2)), off, 32'h0));
                issue(mem_instr(mem_op_e'(4'(3 + next_rand() % 2)), off & ~32'd1, 32'h0));
                issue(mem_instr(mem_lw, off & ~32'd3, 32'h0));
            end else begin
                issue(build(alu_divu, mem_none, next_rand(), next_rand() >> 20, 16'h0, src2_rt));
            end
        end
        finish_test();
        stall_mode = 0;

        cur_test = "flush";
        issue(mem_instr(mem_sw, 32'h400, 32'h0bad_beef));
        finish_test();
        present(build(alu_div, mem_none, 32'd1000, 32'd3, 16'h0, src2_rt));
        repeat (5) @(negedge clk);
        ds_bus   = mem_instr(mem_sw, 32'h400, 32'h55aa_55aa);
        ds_valid = 1'b1;
        @(negedge clk);
        flush    = 1'b1;
        ds_valid = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        present(mem_instr(mem_sw, 32'h400, 32'h1234_5678));
        flush = 1'b1;                // lands on the store's handoff edge
        @(negedge clk);
        flush = 1'b0;
        repeat (div_steps + 5) @(negedge clk);
        issue(mem_instr(mem_lw, 32'h400, 32'h0));
        finish_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
